//--- ptw.f
+incdir+hw
hw/ptw_pkg.sv
hw/ptw_miss_queue.sv
hw/ptw_walker.sv
hw/ptw_tran_buf.sv
hw/ptw_top.sv
testbench/ptw_mem_model.sv
testbench/ptw_tb.sv

//--- testbench/ptw_tb.sv
// ==========================================================================
// Page table walker testbench
// Directed walks through an APB table memory, checking every TLB update
// ==========================================================================

`timescale 1ns/1ns

`include "ptw_config.svh"

module ptw_tb;
	import ptw_pkg::*;

	localparam logic [31:0] SEED = 32'h26dd87d2;
	localparam int PERIOD = 8;
	localparam int NUM_TESTS = 6;
	localparam logic [31:0] TABLE_BASE = 32'h0000_1000;

	logic clk = 1'b0;
	logic rst;
	logic miss_v, commit_v, flush_v, miss_dup, miss_full;
	logic [`PTW_VADR_W-1:0] miss_adr;
	asid_t miss_asid;
	rob_ndx_t miss_id, commit_id, flush_id;
	logic [`PTW_PADR_W-1:0] ptbr, paddr;
	logic tlb_wr, tlb_super, tlb_fault;
	logic [`PTW_VADR_W-13:0] tlb_vpn;
	asid_t tlb_asid;
	logic [`PTW_PADR_W-13:0] tlb_ppn;
	logic [6:0] tlb_flags;
	logic psel, penable, pready, pslverr, err_en;
	logic [31:0] prdata, err_adr;
	logic [2:0] wait_max;

	// Collected TLB updates, one queue per field
	logic [`PTW_VADR_W-13:0] res_vpn [$];
	asid_t res_asid [$];
	logic [`PTW_PADR_W-13:0] res_ppn [$];
	logic [6:0] res_flags [$];
	logic res_super [$];
	logic res_fault [$];
	int dup_cnt;
	int errors = 0;
	int checks = 0;
	int err_base;
	logic [31:0] seed_ret;

	ptw_top uut (
		.clk(clk), .rst(rst), .miss_v(miss_v), .miss_adr(miss_adr), .miss_asid(miss_asid),
		.miss_id(miss_id), .miss_dup(miss_dup), .miss_full(miss_full),
		.commit_id(commit_id), .commit_v(commit_v), .flush_id(flush_id), .flush_v(flush_v),
		.ptbr(ptbr), .tlb_wr(tlb_wr), .tlb_vpn(tlb_vpn), .tlb_asid(tlb_asid),
		.tlb_ppn(tlb_ppn), .tlb_flags(tlb_flags), .tlb_super(tlb_super),
		.tlb_fault(tlb_fault), .paddr(paddr), .psel(psel), .penable(penable),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	ptw_mem_model u_mem (
		.clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .wait_max(wait_max),
		.err_en(err_en), .err_adr(err_adr)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Every update and duplicate pulse seen at a clock edge
	always @(posedge clk) begin
		if (!rst && tlb_wr) begin
			res_vpn.push_back(tlb_vpn);
			res_asid.push_back(tlb_asid);
			res_ppn.push_back(tlb_ppn);
			res_flags.push_back(tlb_flags);
			res_super.push_back(tlb_super);
			res_fault.push_back(tlb_fault);
		end
		if (!rst && miss_dup)
			dup_cnt++;
	end

	// ======================================================================
	// Table layout helpers
	// ======================================================================

	// Level 1 entry sits at the table base plus four times the top ten bits
	function automatic logic [31:0] l1_entry_adr(input logic [31:0] va);
		return TABLE_BASE + {20'h0, va[31:22], 2'b00};
	endfunction

	function automatic logic [31:0] l0_entry_adr(input logic [19:0] ppn, input logic [31:0] va);
		return {ppn, va[21:12], 2'b00};
	endfunction

	// Flags run d a u x w r v from bit 6 down to bit 0
	function automatic logic [31:0] leaf_word(input logic [19:0] ppn, input logic [6:0] flags);
		return {ppn, 5'b0, flags};
	endfunction

	function automatic logic [31:0] dir_word(input logic [19:0] ppn);
		return {ppn, 8'b0, 3'b000, 1'b1};
	endfunction

	function automatic logic [19:0] super_ppn(input logic [19:0] ppn, input logic [31:0] va);
		return {ppn[19:10], va[21:12]};
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task check_ppn(input string name, input logic [`PTW_PADR_W-13:0] exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s ppn: expected %h, actual %h", name, exp, act);
		end
	endtask

	task check_vpn(input string name, input logic [`PTW_VADR_W-13:0] exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s vpn: expected %h, actual %h", name, exp, act);
		end
	endtask

	task check_asid(input string name, input asid_t exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s asid: expected %h, actual %h", name, exp, act);
		end
	endtask

	task check_flags(input string name, input logic [6:0] exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s flags: expected %b, actual %b", name, exp, act);
		end
	endtask

	task check_bit(input string name, input logic exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task check_count(input string name, input int exp, act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task clear_results();
		res_vpn.delete();
		res_asid.delete();
		res_ppn.delete();
		res_flags.delete();
		res_super.delete();
		res_fault.delete();
		dup_cnt = 0;
	endtask

	task start_test();
		clear_results();
		u_mem.clear_words();
		err_base = errors;
	endtask

	task end_test(input string name);
		if (errors == err_base)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_base);
	endtask

	// Holds the miss until the queue has room for it
	task issue_miss(input logic [31:0] va, input asid_t asid, input rob_ndx_t id);
		@(posedge clk);
		miss_v <= 1'b1;
		miss_adr <= va;
		miss_asid <= asid;
		miss_id <= id;
		@(negedge clk);
		while (miss_full)
			@(negedge clk);
		@(posedge clk);
		miss_v <= 1'b0;
	endtask

	task commit(input rob_ndx_t id);
		@(posedge clk);
		commit_v <= 1'b1;
		commit_id <= id;
		@(posedge clk);
		commit_v <= 1'b0;
	endtask

	task flush(input rob_ndx_t id);
		@(posedge clk);
		flush_v <= 1'b1;
		flush_id <= id;
		@(posedge clk);
		flush_v <= 1'b0;
	endtask

	task wait_updates(input string name, input int n, output bit ok);
		int cyc;
		cyc = 0;
		while (res_vpn.size() < n && cyc < 200) begin
			@(negedge clk);
			cyc++;
		end
		ok = (res_vpn.size() >= n);
		if (!ok) begin
			errors++;
			$display("%s: only %0d of %0d TLB updates arrived", name, res_vpn.size(), n);
		end
	endtask

	task walk_one(input string name, input logic [31:0] va, input rob_ndx_t id, output bit ok);
		issue_miss(va, 8'h01, id);
		commit(id);
		wait_updates(name, 1, ok);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task test_two_level();
		logic [31:0] va;
		bit ok;
		va = 32'h0040_5123;
		start_test();
		u_mem.write_word(l1_entry_adr(va), dir_word(20'h00002));
		u_mem.write_word(l0_entry_adr(20'h00002, va), leaf_word(20'h12345, 7'b1100011));
		walk_one("two_level", va, 5'd3, ok);
		if (ok) begin
			check_vpn("two_level", va[31:12], res_vpn[0]);
			check_asid("two_level", 8'h01, res_asid[0]);
			check_ppn("two_level", 20'h12345, res_ppn[0]);
			check_flags("two_level", 7'b1100011, res_flags[0]);
			check_bit("two_level super", 1'b0, res_super[0]);
			check_bit("two_level fault", 1'b0, res_fault[0]);
		end
		end_test("two_level");
	endtask

	task test_superpage();
		logic [31:0] va;
		bit ok;
		va = 32'h0080_7000;
		start_test();
		u_mem.write_word(l1_entry_adr(va), leaf_word(20'hABCDE, 7'b0011011));
		walk_one("superpage", va, 5'd4, ok);
		if (ok) begin
			check_ppn("superpage", super_ppn(20'hABCDE, va), res_ppn[0]);
			check_flags("superpage", 7'b0011011, res_flags[0]);
			check_bit("superpage super", 1'b1, res_super[0]);
			check_bit("superpage fault", 1'b0, res_fault[0]);
		end
		end_test("superpage");
	endtask

	task test_duplicate();
		logic [31:0] va;
		bit ok;
		va = 32'h0040_5abc;
		start_test();
		u_mem.write_word(l1_entry_adr(va), dir_word(20'h00002));
		u_mem.write_word(l0_entry_adr(20'h00002, va), leaf_word(20'h0F0F0, 7'b0000111));
		issue_miss(va, 8'h01, 5'd4);
		issue_miss(32'h0040_5fff, 8'h01, 5'd5);
		commit(5'd4);
		// A duplicate that slipped into its own slot would walk once this commits
		commit(5'd5);
		wait_updates("duplicate", 1, ok);
		// Give a second update time to show up if the duplicate leaked in
		repeat (40) @(posedge clk);
		check_count("duplicate updates", 1, res_vpn.size());
		check_count("duplicate pulses", 1, dup_cnt);
		if (ok)
			check_ppn("duplicate", 20'h0F0F0, res_ppn[0]);
		end_test("duplicate");
	endtask

	// Invalid at level 1, invalid at level 0, pointer at level 0, bus error
	task test_fault();
		logic [31:0] va [4];
		bit ok;
		va[0] = {10'd3, 10'd0, 12'h0};
		va[1] = {10'd4, 10'd9, 12'h0};
		va[2] = {10'd4, 10'd10, 12'h0};
		va[3] = {10'd5, 10'd0, 12'h0};
		start_test();
		u_mem.write_word(l1_entry_adr(va[1]), dir_word(20'h00003));
		u_mem.write_word(l0_entry_adr(20'h00003, va[2]), dir_word(20'h00002));
		u_mem.write_word(l1_entry_adr(va[3]), leaf_word(20'h11111, 7'b0000011));
		@(posedge clk);
		err_en <= 1'b1;
		err_adr <= l1_entry_adr(va[3]);
		for (int k = 0; k < 4; k++) begin
			clear_results();
			walk_one("fault", va[k], rob_ndx_t'(6 + k), ok);
			if (ok) begin
				check_vpn("fault", va[k][31:12], res_vpn[0]);
				check_bit("fault flag", 1'b1, res_fault[0]);
				check_bit("fault super", 1'b0, res_super[0]);
			end
		end
		@(posedge clk);
		err_en <= 1'b0;
		end_test("fault");
	endtask

	task test_flush();
		start_test();
		for (int k = 0; k < 4; k++)
			issue_miss({10'd8, 10'(k), 12'h0}, 8'h03, rob_ndx_t'(10 + k));
		// A new page with every slot taken must see the queue full
		@(posedge clk);
		miss_adr <= 32'h0300_0000;
		@(negedge clk);
		check_bit("flush full before", 1'b1, miss_full);
		flush(5'd11);
		@(negedge clk);
		check_bit("flush full after", 1'b0, miss_full);
		flush(5'd10);
		flush(5'd12);
		flush(5'd13);
		// Committing the dropped ids must not start any walk
		for (int k = 0; k < 4; k++)
			commit(rob_ndx_t'(10 + k));
		repeat (20) @(posedge clk);
		check_count("flush updates", 0, res_vpn.size());
		end_test("flush");
	endtask

	task test_reverse_commit();
		logic [31:0] va [4];
		logic [19:0] exp_ppn [4];
		logic [6:0] exp_flags [4];
		logic exp_super [4];
		bit seen [4];
		bit ok;
		bit found;
		start_test();
		@(posedge clk);
		wait_max <= 3'd3;
		u_mem.write_word(TABLE_BASE + 32'h4, dir_word(20'h00002));
		for (int k = 0; k < 3; k++) begin
			va[k] = {10'd1, 10'(40 + k), 12'h0};
			exp_ppn[k] = 20'h50000 + 20'(k);
			exp_flags[k] = 7'b1000011 | 7'(k << 3);
			exp_super[k] = 1'b0;
			u_mem.write_word(l0_entry_adr(20'h00002, va[k]), leaf_word(exp_ppn[k], exp_flags[k]));
		end
		va[3] = {10'd6, 10'd17, 12'h0};
		exp_flags[3] = 7'b0001111;
		exp_super[3] = 1'b1;
		exp_ppn[3] = super_ppn(20'h7F000, va[3]);
		u_mem.write_word(l1_entry_adr(va[3]), leaf_word(20'h7F000, exp_flags[3]));
		for (int k = 0; k < 4; k++) begin
			seen[k] = 1'b0;
			issue_miss(va[k], 8'h04, rob_ndx_t'(20 + k));
		end
		for (int k = 3; k >= 0; k--)
			commit(rob_ndx_t'(20 + k));
		wait_updates("reverse_commit", 4, ok);
		repeat (20) @(posedge clk);
		check_count("reverse_commit updates", 4, res_vpn.size());
		// Updates may come back in any order, so match them by page
		for (int i = 0; i < res_vpn.size(); i++) begin
			found = 1'b0;
			for (int k = 0; k < 4; k++) begin
				if (!found && !seen[k] && res_vpn[i] == va[k][31:12]) begin
					found = 1'b1;
					seen[k] = 1'b1;
					check_asid("reverse_commit", 8'h04, res_asid[i]);
					check_ppn("reverse_commit", exp_ppn[k], res_ppn[i]);
					check_flags("reverse_commit", exp_flags[k], res_flags[i]);
					check_bit("reverse_commit super", exp_super[k], res_super[i]);
					check_bit("reverse_commit fault", 1'b0, res_fault[i]);
				end
			end
			if (!found) begin
				errors++;
				$display("reverse_commit: unexpected TLB update for page %h", res_vpn[i]);
			end
		end
		@(posedge clk);
		wait_max <= 3'd1;
		end_test("reverse_commit");
	endtask

	// ======================================================================
	// Run control
	// ======================================================================

	initial begin
		#(NUM_TESTS * 2000);
		$display("Timeout: the tests did not finish within %0d ns", NUM_TESTS * 2000);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed_ret = $urandom(SEED);
		rst = 1'b1;
		miss_v = 1'b0;
		miss_adr = '0;
		miss_asid = '0;
		miss_id = '0;
		commit_v = 1'b0;
		commit_id = '0;
		flush_v = 1'b0;
		flush_id = '0;
		ptbr = TABLE_BASE;
		wait_max = 3'd1;
		err_en = 1'b0;
		err_adr = '0;
		u_mem.clear_words();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_two_level();
		test_superpage();
		test_duplicate();
		test_fault();
		test_flush();
		test_reverse_commit();
		$display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- testbench/ptw_mem_model.sv
// ==========================================================================
// APB read completer for the page table walker testbench
// Word storage for page tables, random wait states and an error response
// on one chosen address
// ==========================================================================

`timescale 1ns/1ns

module ptw_mem_model (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] paddr,
	input  logic        psel,
	input  logic        penable,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic [2:0]  wait_max,
	input  logic        err_en,
	input  logic [31:0] err_adr
);

	// 16 KiB of table space, word addressed
	localparam int WORDS = 4096;

	logic [31:0] mem [WORDS];
	logic [2:0]  wait_cnt;

	// Wait count is drawn in the setup phase and counted down in access
	always @(posedge clk) begin
		if (rst)
			wait_cnt <= 3'd0;
		else if (psel && !penable)
			wait_cnt <= 3'($urandom % (int'(wait_max) + 1));
		else if (psel && penable && wait_cnt != 3'd0)
			wait_cnt <= wait_cnt - 3'd1;
	end

	assign pready = psel && penable && (wait_cnt == 3'd0);
	assign prdata = mem[paddr[13:2]];
	assign pslverr = pready && err_en && (paddr == err_adr);

	task write_word(input logic [31:0] adr, input logic [31:0] data);
		mem[adr[13:2]] = data;
	endtask

	// Zero words read back as invalid entries
	task clear_words();
		for (int i = 0; i < WORDS; i++)
			mem[i] = 32'h0;
	endtask

endmodule

//--- hw/ptw_top.sv
// ==========================================================================
// Page table walker top level
// Miss queue, APB read engine and translation buffer between the TLB,
// the commit and flush ports and the memory side
// ==========================================================================

`timescale 1ns/1ns

`include "ptw_config.svh"

module ptw_top
	import ptw_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	// TLB miss side
	input  logic                    miss_v,
	input  logic [`PTW_VADR_W-1:0]  miss_adr,
	input  asid_t                   miss_asid,
	input  rob_ndx_t                miss_id,
	output logic                    miss_dup,
	output logic                    miss_full,
	// Commit and flush from the reorder buffer
	input  rob_ndx_t                commit_id,
	input  logic                    commit_v,
	input  rob_ndx_t                flush_id,
	input  logic                    flush_v,
	input  logic [`PTW_PADR_W-1:0]  ptbr,
	// TLB update
	output logic                    tlb_wr,
	output logic [`PTW_VADR_W-13:0] tlb_vpn,
	output asid_t                   tlb_asid,
	output logic [`PTW_PADR_W-13:0] tlb_ppn,
	output logic [6:0]              tlb_flags,
	output logic                    tlb_super,
	output logic                    tlb_fault,
	// APB read requester
	output logic [`PTW_PADR_W-1:0]  paddr,
	output logic                    psel,
	output logic                    penable,
	input  logic [31:0]             prdata,
	input  logic                    pready,
	input  logic                    pslverr
);

	// Queue to walker
	logic                   walk_req;
	qe_ndx_t                walk_qe;
	logic [`PTW_PADR_W-1:0] walk_tadr;
	logic                   walk_ack;

	// Walker to buffer
	logic    rsp_v;
	qe_ndx_t rsp_qe;
	pte_u    rsp_pte;
	logic    rsp_err;

	// Buffer to queue
	logic    tran_v;
	qe_ndx_t tran_qe;
	pte_u    tran_pte;
	logic    tran_err;

	ptw_miss_queue u_queue (
		.clk(clk), .rst(rst), .miss_v(miss_v), .miss_adr(miss_adr),
		.miss_asid(miss_asid), .miss_id(miss_id), .commit_id(commit_id),
		.commit_v(commit_v), .flush_id(flush_id), .flush_v(flush_v), .ptbr(ptbr),
		.walk_ack(walk_ack), .tran_v(tran_v), .tran_qe(tran_qe), .tran_pte(tran_pte),
		.tran_err(tran_err), .miss_dup(miss_dup), .miss_full(miss_full),
		.walk_req(walk_req), .walk_qe(walk_qe), .walk_tadr(walk_tadr),
		.tlb_wr(tlb_wr), .tlb_vpn(tlb_vpn), .tlb_asid(tlb_asid), .tlb_ppn(tlb_ppn),
		.tlb_flags(tlb_flags), .tlb_super(tlb_super), .tlb_fault(tlb_fault)
	);

	ptw_walker u_walker (
		.clk(clk), .rst(rst), .walk_req(walk_req), .walk_qe(walk_qe),
		.walk_tadr(walk_tadr), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.walk_ack(walk_ack), .paddr(paddr), .psel(psel), .penable(penable),
		.rsp_v(rsp_v), .rsp_qe(rsp_qe), .rsp_pte(rsp_pte), .rsp_err(rsp_err)
	);

	ptw_tran_buf u_tran_buf (
		.clk(clk), .rst(rst), .rsp_v(rsp_v), .rsp_qe(rsp_qe), .rsp_pte(rsp_pte),
		.rsp_err(rsp_err), .tran_v(tran_v), .tran_qe(tran_qe), .tran_pte(tran_pte),
		.tran_err(tran_err)
	);

endmodule

//--- hw/ptw_tran_buf.sv
// ==========================================================================
// Page table walker translation buffer
// Circular buffer of returned entries, each tagged with its queue slot,
// presenting the oldest one per cycle
// ==========================================================================

`timescale 1ns/1ns

`include "ptw_config.svh"

module ptw_tran_buf
	import ptw_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    rsp_v,
	input  qe_ndx_t rsp_qe,
	input  pte_u    rsp_pte,
	input  logic    rsp_err,
	output logic    tran_v,
	output qe_ndx_t tran_qe,
	output pte_u    tran_pte,
	output logic    tran_err
);

	localparam int DEPTH = `PTW_TRANBUF_SIZE;
	localparam int PW = $clog2(DEPTH);

	qe_ndx_t buf_qe  [DEPTH];
	pte_u    buf_pte [DEPTH];
	logic    buf_err [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0]   count;
	logic          full;

	assign full = (count == (PW+1)'(DEPTH));

	// Oldest slot, taken by the queue whenever it is shown
	assign tran_v = (count != '0);
	assign tran_qe = buf_qe[rd_ptr];
	assign tran_pte = buf_pte[rd_ptr];
	assign tran_err = buf_err[rd_ptr];

	// Slot storage
	always_ff @(posedge clk) begin
		if (rsp_v) begin
			buf_qe[wr_ptr] <= rsp_qe;
			buf_pte[wr_ptr] <= rsp_pte;
			buf_err[wr_ptr] <= rsp_err;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (rsp_v)
				wr_ptr <= wr_ptr + 1'b1;
			if (tran_v)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PW+1)'(rsp_v) - (PW+1)'(tran_v);
		end
	end

	// The walker has no back-pressure, so the depth must cover every read
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(rsp_v && full));

endmodule

//--- hw/ptw_walker.sv
// ==========================================================================
// Page table walker APB read engine
// Takes one ready queue slot at a time, reads its table entry over APB
// and hands the word back tagged with the slot index
// ==========================================================================

`timescale 1ns/1ns

`include "ptw_config.svh"

module ptw_walker
	import ptw_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   walk_req,
	input  qe_ndx_t                walk_qe,
	input  logic [`PTW_PADR_W-1:0] walk_tadr,
	input  logic [31:0]            prdata,
	input  logic                   pready,
	input  logic                   pslverr,
	output logic                   walk_ack,
	output logic [`PTW_PADR_W-1:0] paddr,
	output logic                   psel,
	output logic                   penable,
	output logic                   rsp_v,
	output qe_ndx_t                rsp_qe,
	output pte_u                   rsp_pte,
	output logic                   rsp_err
);

	// ======================================================================
	// State encoding
	// ======================================================================

	localparam logic [1:0] IDLE   = 2'd0;
	localparam logic [1:0] SETUP  = 2'd1;
	localparam logic [1:0] ACCESS = 2'd2;
	localparam logic [1:0] RESP   = 2'd3;

	logic [1:0] state;
	logic [1:0] state_nxt;
	qe_ndx_t    cur_qe;

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (walk_req)
					state_nxt = SETUP;
			end
			SETUP: begin
				state_nxt = ACCESS;
			end
			ACCESS: begin
				// Wait states keep the access phase open
				if (pready)
					state_nxt = RESP;
			end
			RESP: begin
				// One idle cycle lets the returned word reach the queue
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Slot and table address are held for the whole transfer
	always_ff @(posedge clk) begin
		if (state == IDLE && walk_req) begin
			cur_qe <= walk_qe;
			paddr <= walk_tadr;
		end
	end

	// ======================================================================
	// APB and response outputs
	// ======================================================================

	assign psel = (state == SETUP) || (state == ACCESS);
	assign penable = (state == ACCESS);

	// The queue marks the slot outstanding during the setup phase
	assign walk_ack = (state == SETUP);

	// Response is valid only in the completing access cycle
	assign rsp_v = (state == ACCESS) && pready;
	assign rsp_qe = cur_qe;
	assign rsp_pte = prdata;
	assign rsp_err = pslverr;

	// Address holds through the transfer and psel stays up until it ends
	a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
		psel && !pready |=> psel && $stable(paddr));

endmodule

//--- hw/ptw_miss_queue.sv
// ==========================================================================
// Page table walker miss queue
// Captures TLB misses, drops duplicates, waits for commit, advances each
// miss through the table levels and issues the final TLB update
// ==========================================================================

`timescale 1ns/1ns

`include "ptw_config.svh"

module ptw_miss_queue
	import ptw_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       miss_v,
	input  logic [`PTW_VADR_W-1:0]     miss_adr,
	input  asid_t                      miss_asid,
	input  rob_ndx_t                   miss_id,
	input  rob_ndx_t                   commit_id,
	input  logic                       commit_v,
	input  rob_ndx_t                   flush_id,
	input  logic                       flush_v,
	input  logic [`PTW_PADR_W-1:0]     ptbr,
	input  logic                       walk_ack,
	input  logic                       tran_v,
	input  qe_ndx_t                    tran_qe,
	input  pte_u                       tran_pte,
	input  logic                       tran_err,
	output logic                       miss_dup,
	output logic                       miss_full,
	output logic                       walk_req,
	output qe_ndx_t                    walk_qe,
	output logic [`PTW_PADR_W-1:0]     walk_tadr,
	output logic                       tlb_wr,
	output logic [`PTW_VADR_W-13:0]    tlb_vpn,
	output asid_t                      tlb_asid,
	output logic [`PTW_PADR_W-13:0]    tlb_ppn,
	output logic [6:0]                 tlb_flags,
	output logic                       tlb_super,
	output logic                       tlb_fault
);

	localparam int N = `PTW_MISSQ_SIZE;
	localparam int VT = `PTW_VADR_W - 1;

	miss_entry_t ent [N];

	logic        dup_hit;
	logic        free_found;
	qe_ndx_t     free_qe;
	qe_ndx_t     ack_qe;
	logic        dup_pair;
	miss_entry_t tran_ent;
	logic        tran_leaf;
	logic        tran_fault;
	logic        tran_next;

	// ======================================================================
	// Searches over the queue
	// ======================================================================

	// Duplicate test on asid and page, and the lowest free slot
	always_comb begin
		dup_hit = 1'b0;
		free_found = 1'b0;
		free_qe = '0;
		for (int i = 0; i < N; i++) begin
			if (ent[i].v && ent[i].asid == miss_asid && ent[i].adr[VT:12] == miss_adr[VT:12])
				dup_hit = 1'b1;
			if (!ent[i].v && !free_found) begin
				free_found = 1'b1;
				free_qe = qe_ndx_t'(i);
			end
		end
	end

	// The TLB must hold its miss while this is high
	assign miss_full = !free_found && !dup_hit;

	// Lowest committed entry that is ready and has no read in flight
	always_comb begin
		walk_req = 1'b0;
		walk_qe = '0;
		for (int i = 0; i < N; i++) begin
			if (!walk_req && ent[i].v && ent[i].committed && ent[i].rdy && !ent[i].o) begin
				walk_req = 1'b1;
				walk_qe = qe_ndx_t'(i);
			end
		end
	end

	assign walk_tadr = ent[walk_qe].tadr;

	// Decode of the entry word returned for one queue slot
	assign tran_ent = ent[tran_qe];
	assign tran_leaf = tran_pte.leaf.r | tran_pte.leaf.w | tran_pte.leaf.x;
	// A pointer found at level 0 has nowhere left to go
	assign tran_fault = tran_err | ~tran_pte.leaf.v | (~tran_leaf & ~tran_ent.lvl);
	assign tran_next = ~tran_fault & ~tran_leaf;

	// ======================================================================
	// Queue state
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N; i++) begin
				ent[i].v <= 1'b0;
				ent[i].o <= 1'b0;
				ent[i].rdy <= 1'b0;
				ent[i].committed <= 1'b0;
			end
			miss_dup <= 1'b0;
			tlb_wr <= 1'b0;
		end else begin
			miss_dup <= miss_v & dup_hit;
			tlb_wr <= 1'b0;
			// Commit marks an entry walkable, flush drops one not yet committed
			for (int i = 0; i < N; i++) begin
				if (ent[i].v && commit_v && ent[i].id == commit_id)
					ent[i].committed <= 1'b1;
				if (ent[i].v && !ent[i].committed && flush_v && ent[i].id == flush_id)
					ent[i].v <= 1'b0;
			end
			// New miss starts at level 1 indexed by the top ten address bits
			if (miss_v && !dup_hit && free_found) begin
				ent[free_qe].v <= 1'b1;
				ent[free_qe].o <= 1'b0;
				ent[free_qe].rdy <= 1'b1;
				ent[free_qe].lvl <= 1'b1;
				ent[free_qe].committed <= commit_v && commit_id == miss_id;
				ent[free_qe].asid <= miss_asid;
				ent[free_qe].id <= miss_id;
				ent[free_qe].adr <= miss_adr;
				ent[free_qe].tadr <= ptbr + `PTW_PADR_W'({miss_adr[VT -: 10], 2'b00});
			end
			// The walker acknowledges the slot it latched one cycle earlier
			if (walk_ack) begin
				ent[ack_qe].rdy <= 1'b0;
				ent[ack_qe].o <= 1'b1;
			end
			if (tran_v) begin
				ent[tran_qe].o <= 1'b0;
				if (tran_next) begin
					ent[tran_qe].lvl <= 1'b0;
					ent[tran_qe].rdy <= 1'b1;
					ent[tran_qe].tadr <= {tran_pte.dir.ppn, tran_ent.adr[21:12], 2'b00};
				end else begin
					ent[tran_qe].v <= 1'b0;
					tlb_wr <= 1'b1;
				end
			end
		end
	end

	// Update payload, qualified by tlb_wr
	always_ff @(posedge clk) begin
		ack_qe <= walk_qe;
		if (tran_v && !tran_next) begin
			tlb_vpn <= tran_ent.adr[VT:12];
			tlb_asid <= tran_ent.asid;
			tlb_super <= tran_ent.lvl & ~tran_fault;
			tlb_fault <= tran_fault;
			tlb_flags <= {tran_pte.leaf.d, tran_pte.leaf.a, tran_pte.leaf.u, tran_pte.leaf.x,
				tran_pte.leaf.w, tran_pte.leaf.r, tran_pte.leaf.v};
			// Superpages take the low half of the page number from the address
			if (tran_ent.lvl)
				tlb_ppn <= {tran_pte.leaf.ppn[19:10], tran_ent.adr[21:12]};
			else
				tlb_ppn <= tran_pte.leaf.ppn;
		end
	end

	// Any two live entries that collide on asid and page
	always_comb begin
		dup_pair = 1'b0;
		for (int i = 0; i < N; i++)
			for (int j = i + 1; j < N; j++)
				if (ent[i].v && ent[j].v && ent[i].asid == ent[j].asid &&
					ent[i].adr[VT:12] == ent[j].adr[VT:12])
					dup_pair = 1'b1;
	end

	// Returned entries only ever belong to a slot with a read in flight
	a_tran_owner: assert property (@(posedge clk) disable iff (rst)
		tran_v |-> ent[tran_qe].v && ent[tran_qe].o);

	// Duplicate filtering keeps each page in at most one slot
	a_no_dup: assert property (@(posedge clk) disable iff (rst) !dup_pair);

endmodule

//--- hw/ptw_pkg.sv
// ==========================================================================
// Page table walker types
// Queue entry layout, the two decodings of a page table entry word and
// the index types shared by the walker blocks
// ==========================================================================

`include "ptw_config.svh"

package ptw_pkg;

	// Index of a miss queue slot
	typedef logic [$clog2(`PTW_MISSQ_SIZE)-1:0] qe_ndx_t;

	// Reorder-buffer id and address space id
	typedef logic [`PTW_ROB_W-1:0] rob_ndx_t;
	typedef logic [`PTW_ASID_W-1:0] asid_t;

	// Entry seen as a leaf. Any of r, w or x set makes it one
	typedef struct packed {
		logic [19:0] ppn;
		logic [4:0]  rsv;
		logic        d;
		logic        a;
		logic        u;
		logic        x;
		logic        w;
		logic        r;
		logic        v;
	} pte_leaf_t;

	// Entry seen as a pointer to the next level table
	typedef struct packed {
		logic [19:0] ppn;
		logic [7:0]  rsv;
		logic [2:0]  perm;
		logic        v;
	} pte_dir_t;

	// The same word read either way, the leaf test picks the view
	typedef union packed {
		pte_leaf_t leaf;
		pte_dir_t  dir;
	} pte_u;

	// One outstanding miss
	typedef struct packed {
		logic                  v;
		logic                  o;
		logic                  rdy;
		logic                  lvl;
		logic                  committed;
		asid_t                 asid;
		rob_ndx_t              id;
		logic [`PTW_VADR_W-1:0] adr;
		logic [`PTW_PADR_W-1:0] tadr;
	} miss_entry_t;

endpackage

//--- hw/ptw_config.svh
// ==========================================================================
// Page table walker build constants
// Sizes of the miss queue and translation buffer, and the address,
// reorder-buffer id and address space id widths
// ==========================================================================

`ifndef PTW_CONFIG_SVH
`define PTW_CONFIG_SVH

// Number of outstanding misses the queue can track
`define PTW_MISSQ_SIZE 4

// Translation buffer depth, matched to the queue so it never overflows
`define PTW_TRANBUF_SIZE 4

// Virtual and physical address widths, both with 4 KiB pages
`define PTW_VADR_W 32
`define PTW_PADR_W 32

// Reorder-buffer id width of the core
`define PTW_ROB_W 5

// Address space id width
`define PTW_ASID_W 8

`endif
